// ==== hw/uart_str_pkg.sv ====
//////////////////////////////////////////////////
// string link constants: payload limit, packed
// string and length widths, UART bit timing and
// the frame delimiter byte
//////////////////////////////////////////////////

package uart_str_pkg;

	// most payload bytes in one frame
	localparam int MAX_STR_LEN = 32;

	// packed string, byte 0 in the low bits and sent first
	localparam int STR_W = MAX_STR_LEN * 8;

	// length field, holds 0 to MAX_STR_LEN
	localparam int LEN_W = $clog2(MAX_STR_LEN + 1);

	// clock cycles per UART bit, small for simulation
	localparam int CLKS_PER_BIT = 16;

	// ASCII '&', opens and closes a frame in pairs
	localparam logic [7:0] FRAME_DELIM = 8'h26;

endpackage

// ==== hw/byte_tx_if.sv ====
//////////////////////////////////////////////////
// byte request link from the string framer to
// the UART serializer
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface byte_tx_if;

	logic [7:0] data;
	logic       req;
	logic       busy;
	logic       done;

	// req is a single-cycle strobe, only while busy is low
	modport src (output data, output req, input busy, input done);

	// done pulses as busy falls after the stop bit
	modport sink (input data, input req, output busy, output done);

endinterface

// ==== hw/uart_tx.sv ====
//////////////////////////////////////////////////
// 8N1 UART serializer, one byte per request
//////////////////////////////////////////////////

`timescale 1ns/1ps

module uart_tx #(
	parameter int clks_per_bit = uart_str_pkg::CLKS_PER_BIT
) (
	input  logic    sys_clk,
	input  logic    sys_rst_n,
	byte_tx_if.sink byte_if,
	output logic    tx
);

	logic [$clog2(clks_per_bit)-1:0] clk_cnt;
	logic [3:0]                      bit_cnt;
	logic [8:0]                      shreg;
	logic                            bit_end;
	logic                            start;

	assign start   = byte_if.req && !byte_if.busy;
	assign bit_end = (int'(clk_cnt) == clks_per_bit - 1);

	// bit_cnt 0 is the start bit, 1..8 data, 9 the stop bit
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tx           <= 1'b1;
			byte_if.busy <= 1'b0;
			byte_if.done <= 1'b0;
			clk_cnt      <= '0;
			bit_cnt      <= '0;
		end else begin
			byte_if.done <= 1'b0;
			if (start) begin
				// line drops to the start bit on the next cycle
				tx           <= 1'b0;
				byte_if.busy <= 1'b1;
				clk_cnt      <= '0;
				bit_cnt      <= '0;
			end else if (byte_if.busy) begin
				if (bit_end) begin
					clk_cnt <= '0;
					if (bit_cnt == 4'd9) begin
						byte_if.busy <= 1'b0;
						byte_if.done <= 1'b1;
					end else begin
						tx      <= shreg[0];
						bit_cnt <= bit_cnt + 4'd1;
					end
				end else begin
					clk_cnt <= clk_cnt + 1'b1;
				end
			end
		end
	end

	// data LSB first, stop bit shifted in behind it
	always_ff @(posedge sys_clk) begin
		if (start) begin
			shreg <= {1'b1, byte_if.data};
		end else if (byte_if.busy && bit_end) begin
			shreg <= {1'b1, shreg[8:1]};
		end
	end

endmodule

// ==== hw/uart_rx.sv ====
//////////////////////////////////////////////////
// 8N1 UART deserializer with a two-flop input
// synchronizer, mid-bit sampling, stop-bit check
//////////////////////////////////////////////////

`timescale 1ns/1ps

module uart_rx #(
	parameter int clks_per_bit = uart_str_pkg::CLKS_PER_BIT
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       rx,
	output logic [7:0] rx_data,
	output logic       rx_vld,
	output logic       rx_err
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_START,
		S_DATA,
		S_STOP,
		S_TAIL
	} state_t;

	state_t                          state;
	logic [$clog2(clks_per_bit)-1:0] clk_cnt;
	logic [2:0]                      bit_cnt;
	logic                            rx_meta;
	logic                            rx_sync;
	logic                            rx_prev;
	logic                            stop_ok;
	logic                            start_edge;
	logic                            half_pt;
	logic                            bit_end;
	logic                            tail_end;

	assign start_edge = rx_prev && !rx_sync;
	assign half_pt    = (int'(clk_cnt) == clks_per_bit / 2 - 1);
	assign bit_end    = (int'(clk_cnt) == clks_per_bit - 1);
	// back in idle just before the stop bit ends, ready for a back-to-back start
	assign tail_end   = (int'(clk_cnt) >= clks_per_bit / 2 - 3);

	// line idles high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= S_IDLE;
			clk_cnt <= '0;
			bit_cnt <= '0;
			stop_ok <= 1'b0;
			rx_vld  <= 1'b0;
			rx_err  <= 1'b0;
		end else begin
			rx_vld <= 1'b0;
			rx_err <= 1'b0;
			case (state)
				S_IDLE: begin
					clk_cnt <= '0;
					if (start_edge) begin
						state <= S_START;
					end
				end
				S_START: begin
					// glitch shorter than half a bit goes back to idle
					if (half_pt) begin
						clk_cnt <= '0;
						bit_cnt <= '0;
						state   <= rx_sync ? S_IDLE : S_DATA;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				S_DATA: begin
					if (bit_end) begin
						clk_cnt <= '0;
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7) begin
							state <= S_STOP;
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				S_STOP: begin
					if (bit_end) begin
						clk_cnt <= '0;
						stop_ok <= rx_sync;
						state   <= S_TAIL;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				S_TAIL: begin
					if (tail_end) begin
						rx_vld <= stop_ok;
						rx_err <= !stop_ok;
						state  <= S_IDLE;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// LSB arrives first
	always_ff @(posedge sys_clk) begin
		if (state == S_DATA && bit_end) begin
			rx_data <= {rx_sync, rx_data[7:1]};
		end
	end

endmodule

// ==== hw/str_framer.sv ====
//////////////////////////////////////////////////
// string framer: sends "&&" + payload + "&&"
// one byte request at a time
//////////////////////////////////////////////////

`timescale 1ns/1ps

module str_framer (
	input  logic                           sys_clk,
	input  logic                           sys_rst_n,
	input  logic [uart_str_pkg::STR_W-1:0] tx_string,
	input  logic [uart_str_pkg::LEN_W-1:0] tx_length,
	input  logic                           tx_req,
	output logic                           tx_busy,
	output logic                           tx_done,
	byte_tx_if.src                         byte_if
);

	import uart_str_pkg::*;

	typedef enum logic [5:0] {
		S_IDLE   = 6'b000001,
		S_OPEN1  = 6'b000010,
		S_OPEN2  = 6'b000100,
		S_BODY   = 6'b001000,
		S_CLOSE1 = 6'b010000,
		S_CLOSE2 = 6'b100000
	} state_t;

	state_t           state;
	logic             issued;
	logic [LEN_W-1:0] byte_cnt;
	logic [STR_W-1:0] str_q;
	logic [LEN_W-1:0] len_q;
	logic             accept;
	logic             issue;
	logic [7:0]       next_byte;

	assign accept    = tx_req && (state == S_IDLE);
	assign tx_busy   = (state != S_IDLE);
	// one request per state, then wait for the serializer's done
	assign issue     = (state != S_IDLE) && !issued && !byte_if.busy;
	assign next_byte = (state == S_BODY) ? str_q[byte_cnt*8 +: 8] : FRAME_DELIM;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state       <= S_IDLE;
			issued      <= 1'b0;
			byte_cnt    <= '0;
			byte_if.req <= 1'b0;
			tx_done     <= 1'b0;
		end else begin
			byte_if.req <= 1'b0;
			tx_done     <= 1'b0;
			if (accept) begin
				state <= S_OPEN1;
			end else if (issue) begin
				byte_if.req <= 1'b1;
				issued      <= 1'b1;
			end else if (issued && byte_if.done) begin
				issued <= 1'b0;
				case (state)
					S_OPEN1: state <= S_OPEN2;
					S_OPEN2: begin
						byte_cnt <= '0;
						// empty string goes straight to the closing pair
						state    <= (len_q == '0) ? S_CLOSE1 : S_BODY;
					end
					S_BODY: begin
						if (byte_cnt == len_q - 1'b1) begin
							state <= S_CLOSE1;
						end else begin
							byte_cnt <= byte_cnt + 1'b1;
						end
					end
					S_CLOSE1: state <= S_CLOSE2;
					S_CLOSE2: begin
						state   <= S_IDLE;
						tx_done <= 1'b1;
					end
					default: state <= S_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (accept) begin
			str_q <= tx_string;
			len_q <= tx_length;
		end
		if (issue) begin
			byte_if.data <= next_byte;
		end
	end

endmodule

// ==== hw/str_deframer.sv ====
//////////////////////////////////////////////////
// string deframer: finds "&&" delimited frames in
// the received byte stream, collects the payload
//////////////////////////////////////////////////

`timescale 1ns/1ps

module str_deframer (
	input  logic                           sys_clk,
	input  logic                           sys_rst_n,
	input  logic [7:0]                     rx_data,
	input  logic                           rx_vld,
	input  logic                           rx_err,
	output logic [uart_str_pkg::STR_W-1:0] rx_string,
	output logic [uart_str_pkg::LEN_W-1:0] rx_length,
	output logic                           rx_busy,
	output logic                           rx_done
);

	import uart_str_pkg::*;

	// SKIP/SKIP2 drop the rest of an abandoned frame up to its closing pair
	typedef enum logic [2:0] {
		S_HUNT,
		S_OPEN2,
		S_BODY,
		S_CLOSE2,
		S_SKIP,
		S_SKIP2
	} state_t;

	state_t           state;
	logic [LEN_W-1:0] byte_cnt;
	logic [STR_W-1:0] work_buf;
	logic             is_delim;
	logic             buf_full;
	logic             store;
	logic             publish;

	assign is_delim = (rx_data == FRAME_DELIM);
	assign buf_full = (byte_cnt == LEN_W'(MAX_STR_LEN));
	assign store    = rx_vld && (state == S_BODY) && !is_delim && !buf_full;
	assign publish  = rx_vld && (state == S_CLOSE2) && is_delim;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= S_HUNT;
			byte_cnt  <= '0;
			rx_length <= '0;
			rx_busy   <= 1'b0;
			rx_done   <= 1'b0;
		end else begin
			rx_done <= 1'b0;
			if (rx_err) begin
				rx_busy <= 1'b0;
				if (state == S_OPEN2 || state == S_BODY || state == S_CLOSE2) begin
					state <= S_SKIP;
				end else if (state == S_SKIP2) begin
					state <= S_SKIP;
				end
			end else if (rx_vld) begin
				case (state)
					S_HUNT: begin
						if (is_delim) begin
							state <= S_OPEN2;
						end
					end
					S_OPEN2: begin
						if (is_delim) begin
							state    <= S_BODY;
							byte_cnt <= '0;
							rx_busy  <= 1'b1;
						end else begin
							state <= S_HUNT;
						end
					end
					S_BODY: begin
						if (is_delim) begin
							state <= S_CLOSE2;
						end else if (buf_full) begin
							// one byte too many
							state   <= S_SKIP;
							rx_busy <= 1'b0;
						end else begin
							byte_cnt <= byte_cnt + 1'b1;
						end
					end
					S_CLOSE2: begin
						rx_busy <= 1'b0;
						if (is_delim) begin
							state     <= S_HUNT;
							rx_length <= byte_cnt;
							rx_done   <= 1'b1;
						end else begin
							state <= S_SKIP;
						end
					end
					S_SKIP:  state <= is_delim ? S_SKIP2 : S_SKIP;
					S_SKIP2: state <= is_delim ? S_HUNT : S_SKIP;
					default: state <= S_HUNT;
				endcase
			end
		end
	end

	// published copy stays put until the next complete frame
	always_ff @(posedge sys_clk) begin
		if (store) begin
			work_buf[byte_cnt*8 +: 8] <= rx_data;
		end
		if (publish) begin
			rx_string <= work_buf;
		end
	end

endmodule

// ==== hw/uart_str_top.sv ====
//////////////////////////////////////////////////
// UART string link top: framer and serializer on
// the transmit side, deserializer and deframer on
// the receive side
//////////////////////////////////////////////////

`timescale 1ns/1ps

module uart_str_top (
	input  logic                           sys_clk,
	input  logic                           sys_rst_n,

	input  logic [uart_str_pkg::STR_W-1:0] tx_string,
	input  logic [uart_str_pkg::LEN_W-1:0] tx_length,
	input  logic                           tx_req,
	output logic                           tx_busy,
	output logic                           tx_done,

	output logic [uart_str_pkg::STR_W-1:0] rx_string,
	output logic [uart_str_pkg::LEN_W-1:0] rx_length,
	output logic                           rx_busy,
	output logic                           rx_done,

	input  logic                           uart_rx_port,
	output logic                           uart_tx_port
);

	logic [7:0] rx_data;
	logic       rx_vld;
	logic       rx_err;

	byte_tx_if byte_if ();

	// transmit path
	str_framer str_framer_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_string (tx_string),
		.tx_length (tx_length),
		.tx_req    (tx_req),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.byte_if   (byte_if.src)
	);

	uart_tx uart_tx_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.byte_if   (byte_if.sink),
		.tx        (uart_tx_port)
	);

	// receive path
	uart_rx uart_rx_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx        (uart_rx_port),
		.rx_data   (rx_data),
		.rx_vld    (rx_vld),
		.rx_err    (rx_err)
	);

	str_deframer str_deframer_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_data   (rx_data),
		.rx_vld    (rx_vld),
		.rx_err    (rx_err),
		.rx_string (rx_string),
		.rx_length (rx_length),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done)
	);

endmodule

// ==== tb/tb_clk_gen.sv ====
//////////////////////////////////////////////////
// testbench clock, 10 ns period, and an
// active-low reset held for 8 cycles
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clk_gen (
	output logic sys_clk,
	output logic sys_rst_n
);

	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	// release just after an edge, like the rest of the stimulus
	initial begin
		sys_rst_n = 1'b0;
		repeat (8) @(posedge sys_clk);
		#1;
		sys_rst_n = 1'b1;
	end

endmodule

// ==== tb/tb_uart_str.sv ====
//////////////////////////////////////////////////
// UART string link testbench: loopback round
// trips, busy handshake, bit-banged noise and
// invalid frames, scoreboard and assertions
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_uart_str;

	import uart_str_pkg::*;

	// 7 loopback frames, 3 valid and 2 invalid bit-banged ones
	localparam int N_FRAMES    = 12;
	localparam int BYTES_TOTAL = N_FRAMES * (MAX_STR_LEN + 5) + 16;
	// long enough for a stray five-byte frame to come back
	localparam int QUIET_CYCLES = (5 + 5) * 10 * CLKS_PER_BIT;
	// one byte time plus framer turnaround per byte, reset and gaps on top
	localparam int CYCLE_LIMIT = BYTES_TOTAL * (10 * CLKS_PER_BIT + 8) + QUIET_CYCLES + 4000;

	logic             sys_clk;
	logic             sys_rst_n;
	logic [STR_W-1:0] tx_string;
	logic [LEN_W-1:0] tx_length;
	logic             tx_req;
	logic             tx_busy;
	logic             tx_done;
	logic [STR_W-1:0] rx_string;
	logic [LEN_W-1:0] rx_length;
	logic             rx_busy;
	logic             rx_done;
	logic             uart_rx_port;
	logic             uart_tx_port;

	logic             loopback;
	logic             bb_line;
	logic             req_seen;
	logic [STR_W-1:0] exp_str_q[$];
	int               exp_len_q[$];
	logic [7:0]       line_q[$];
	int               frames_expected;
	int               rx_done_cnt;
	int               accepted_cnt;
	int               cycle_cnt;

	assign uart_rx_port = loopback ? uart_tx_port : bb_line;

	tb_clk_gen tb_clk_gen_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n)
	);

	uart_str_top uart_str_top_i (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_string    (tx_string),
		.tx_length    (tx_length),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_string    (rx_string),
		.rx_length    (rx_length),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "stopped at the first failing check");
	endtask

	// quiet outputs and idle line until the first request
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!req_seen |-> (!tx_busy && !tx_done && !rx_busy && !rx_done && uart_tx_port))
		else abort_run("outputs not idle between reset and the first request");

	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(tx_req && !tx_busy) |=> tx_busy)
		else abort_run("tx_busy did not rise after an accepted tx_req");

	// busy may only fall together with the done pulse
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$fell(tx_busy) |-> tx_done)
		else abort_run("tx_busy fell without tx_done");

	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |-> $fell(tx_busy))
		else abort_run("tx_done pulsed while tx_busy was not falling");

	// receive side is busy through the frame and drops with rx_done
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_done |-> $fell(rx_busy))
		else abort_run("rx_done pulsed while rx_busy was not falling");

	always @(posedge sys_clk) begin
		cycle_cnt++;
		if (cycle_cnt > CYCLE_LIMIT) begin
			abort_run($sformatf("timeout, run exceeded %0d cycles", CYCLE_LIMIT));
		end
		if (sys_rst_n && tx_req && !tx_busy) begin
			accepted_cnt++;
		end
	end

	always @(posedge sys_clk) begin : scoreboard
		logic [STR_W-1:0] exp_str;
		int               exp_len;
		if (sys_rst_n && rx_done) begin
			rx_done_cnt++;
			assert (exp_len_q.size() > 0)
				else abort_run("rx_done pulsed with no frame outstanding");
			exp_str = exp_str_q.pop_front();
			exp_len = exp_len_q.pop_front();
			assert (int'(rx_length) == exp_len)
				else abort_run($sformatf("ERR @%0t: rx_length %0d, expected %0d",
					$time, rx_length, exp_len));
			for (int i = 0; i < exp_len; i++) begin
				assert (rx_string[i*8 +: 8] == exp_str[i*8 +: 8])
					else abort_run($sformatf("ERR @%0t: rx_string byte %0d is %h, expected %h",
						$time, i, rx_string[i*8 +: 8], exp_str[i*8 +: 8]));
			end
		end
	end

	// printable ASCII without the delimiter
	function automatic logic [7:0] printable_char();
		logic [7:0] c;
		c = FRAME_DELIM;
		while (c == FRAME_DELIM) begin
			c = 8'(33 + $urandom_range(0, 93));
		end
		return c;
	endfunction

	function automatic logic [STR_W-1:0] make_payload(input int len);
		logic [STR_W-1:0] s;
		s = '0;
		for (int i = 0; i < len; i++) begin
			s[i*8 +: 8] = printable_char();
		end
		return s;
	endfunction

	task automatic expect_frame(input logic [STR_W-1:0] s, input int len);
		exp_str_q.push_back(s);
		exp_len_q.push_back(len);
		frames_expected++;
	endtask

	task automatic wait_frames();
		while (rx_done_cnt < frames_expected) begin
			@(posedge sys_clk);
			#1;
		end
	endtask

	task automatic send_string(input logic [STR_W-1:0] s, input int len);
		while (tx_busy) begin
			@(posedge sys_clk);
			#1;
		end
		tx_string = s;
		tx_length = LEN_W'(len);
		tx_req    = 1'b1;
		req_seen  = 1'b1;
		expect_frame(s, len);
		@(posedge sys_clk);
		#1;
		tx_req = 1'b0;
	endtask

	task automatic queue_frame(input logic [STR_W-1:0] s, input int len);
		line_q.push_back(FRAME_DELIM);
		line_q.push_back(FRAME_DELIM);
		for (int i = 0; i < len; i++) begin
			line_q.push_back(s[i*8 +: 8]);
		end
		line_q.push_back(FRAME_DELIM);
		line_q.push_back(FRAME_DELIM);
	endtask

	// sends line_q at 8N1, the byte at bad_stop_at gets a low stop bit
	task automatic bang_line(input int bad_stop_at);
		logic [9:0] bits;
		int         idx;
		idx = 0;
		while (line_q.size() > 0) begin
			bits = {(idx != bad_stop_at), line_q.pop_front(), 1'b0};
			for (int b = 0; b < 10; b++) begin
				bb_line = bits[b];
				repeat (CLKS_PER_BIT) @(posedge sys_clk);
				#1;
			end
			if (!bits[9]) begin
				// idle again so the next start edge is seen
				bb_line = 1'b1;
				repeat (2 * CLKS_PER_BIT) @(posedge sys_clk);
				#1;
			end
			idx++;
		end
		bb_line = 1'b1;
		repeat (2 * CLKS_PER_BIT) @(posedge sys_clk);
		#1;
	endtask

	task automatic bang_valid_frame();
		logic [STR_W-1:0] s;
		int               n;
		n = $urandom_range(1, MAX_STR_LEN);
		s = make_payload(n);
		queue_frame(s, n);
		expect_frame(s, n);
		bang_line(-1);
		wait_frames();
	endtask

	initial begin : stimulus
		logic [STR_W-1:0] s;
		int               n;
		void'($urandom(32'hb6e6_29b6));
		tx_string       = '0;
		tx_length       = '0;
		tx_req          = 1'b0;
		loopback        = 1'b1;
		bb_line         = 1'b1;
		req_seen        = 1'b0;
		frames_expected = 0;
		rx_done_cnt     = 0;
		accepted_cnt    = 0;
		cycle_cnt       = 0;
		while (sys_rst_n !== 1'b1) begin
			@(posedge sys_clk);
		end
		repeat (20) @(posedge sys_clk);
		#1;

		// loopback, edge lengths first
		send_string(make_payload(0), 0);
		wait_frames();
		send_string(make_payload(1), 1);
		wait_frames();
		send_string(make_payload(MAX_STR_LEN), MAX_STR_LEN);
		wait_frames();
		repeat (3) begin
			n = $urandom_range(2, MAX_STR_LEN - 1);
			send_string(make_payload(n), n);
			wait_frames();
		end

		// second request in the middle of a frame is dropped
		n = $urandom_range(2, MAX_STR_LEN);
		send_string(make_payload(n), n);
		repeat (4 * CLKS_PER_BIT) @(posedge sys_clk);
		#1;
		assert (tx_busy) else abort_run("tx_busy low in the middle of a frame");
		tx_string = make_payload(5);
		tx_length = LEN_W'(5);
		tx_req    = 1'b1;
		@(posedge sys_clk);
		#1;
		tx_req = 1'b0;
		wait_frames();
		// a frame from the dropped request would come back in this window
		repeat (QUIET_CYCLES) @(posedge sys_clk);
		#1;
		assert (accepted_cnt == rx_done_cnt)
			else abort_run($sformatf("ERR @%0t: %0d requests accepted, %0d frames received",
				$time, accepted_cnt, rx_done_cnt));

		// noise, then a lone delimiter and a letter, then one frame
		loopback = 1'b0;
		repeat (6) line_q.push_back(printable_char());
		line_q.push_back(FRAME_DELIM);
		line_q.push_back(8'h71);
		bang_line(-1);
		bang_valid_frame();

		// one payload byte too many
		line_q.push_back(FRAME_DELIM);
		line_q.push_back(FRAME_DELIM);
		repeat (MAX_STR_LEN + 1) line_q.push_back(printable_char());
		line_q.push_back(FRAME_DELIM);
		line_q.push_back(FRAME_DELIM);
		bang_line(-1);
		bang_valid_frame();

		// low stop bit on the third payload byte
		s = make_payload(6);
		queue_frame(s, 6);
		bang_line(4);
		bang_valid_frame();

		if (exp_len_q.size() == 0 && rx_done_cnt == frames_expected) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			abort_run("expected frames still outstanding at the end of the run");
		end
	end

endmodule

// ==== files.f ====
hw/uart_str_pkg.sv
hw/byte_tx_if.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/str_framer.sv
hw/str_deframer.sv
hw/uart_str_top.sv
tb/tb_clk_gen.sv
tb/tb_uart_str.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_uart_str
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
